// ==== files.f ====
hw/adam_pkg.sv
hw/adam_mem.sv
hw/adam_axil_to_mem.sv
hw/adam_syscfg.sv
hw/adam_fabric.sv
hw/adam.sv
tb/adam_tb.sv

// ==== hw/adam.sv ====
`timescale 1ns/10ps

module adam (
    input  logic            clk_i,
    input  logic            reset_i,

    input  adam_pkg::addr_t s_awaddr_i,
    input  logic            s_awvalid_i,
    output logic            s_awready_o,

    input  adam_pkg::data_t s_wdata_i,
    input  adam_pkg::strb_t s_wstrb_i,
    input  logic            wtag_i,
    input  logic            s_wvalid_i,
    output logic            s_wready_o,

    output adam_pkg::resp_t s_bresp_o,
    output logic            s_bvalid_o,
    input  logic            s_bready_i,

    input  adam_pkg::addr_t s_araddr_i,
    input  logic            s_arvalid_i,
    output logic            s_arready_o,

    output adam_pkg::data_t s_rdata_o,
    output adam_pkg::tag_t  rtag_o,
    output adam_pkg::resp_t s_rresp_o,
    output logic            s_rvalid_o,
    input  logic            s_rready_i
);

    import adam_pkg::*;

    // Fabric to memory bridge
    addr_t mem_awaddr;
    logic  mem_awvalid;
    logic  mem_awready;
    data_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_wtag;
    logic  mem_wvalid;
    logic  mem_wready;
    resp_t mem_bresp;
    logic  mem_bvalid;
    logic  mem_bready;
    addr_t mem_araddr;
    logic  mem_arvalid;
    logic  mem_arready;
    data_t mem_rdata;
    tag_t  mem_rtag;
    resp_t mem_rresp;
    logic  mem_rvalid;
    logic  mem_rready;

    // Fabric to syscfg
    addr_t cfg_awaddr;
    logic  cfg_awvalid;
    logic  cfg_awready;
    data_t cfg_wdata;
    strb_t cfg_wstrb;
    logic  cfg_wvalid;
    logic  cfg_wready;
    resp_t cfg_bresp;
    logic  cfg_bvalid;
    logic  cfg_bready;
    addr_t cfg_araddr;
    logic  cfg_arvalid;
    logic  cfg_arready;
    data_t cfg_rdata;
    resp_t cfg_rresp;
    logic  cfg_rvalid;
    logic  cfg_rready;

    logic mem_pause_req;
    logic mem_pause_ack;

    // Bridge to data and tag RAMs
    logic                         ram_req;
    logic                         ram_we;
    logic [$clog2(MEM_WORDS)-1:0] ram_index;
    strb_t                        ram_be;
    data_t                        ram_wdata;
    data_t                        ram_rdata;
    tag_t                         tag_wdata;
    tag_t                         tag_rdata;

    adam_fabric i_fabric (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .s_awaddr_i    (s_awaddr_i),
        .s_awvalid_i   (s_awvalid_i),
        .s_awready_o   (s_awready_o),
        .s_wdata_i     (s_wdata_i),
        .s_wstrb_i     (s_wstrb_i),
        .s_wtag_i      (wtag_i),
        .s_wvalid_i    (s_wvalid_i),
        .s_wready_o    (s_wready_o),
        .s_bresp_o     (s_bresp_o),
        .s_bvalid_o    (s_bvalid_o),
        .s_bready_i    (s_bready_i),
        .s_araddr_i    (s_araddr_i),
        .s_arvalid_i   (s_arvalid_i),
        .s_arready_o   (s_arready_o),
        .s_rdata_o     (s_rdata_o),
        .s_rtag_o      (rtag_o),
        .s_rresp_o     (s_rresp_o),
        .s_rvalid_o    (s_rvalid_o),
        .s_rready_i    (s_rready_i),
        .mem_awaddr_o  (mem_awaddr),
        .mem_awvalid_o (mem_awvalid),
        .mem_awready_i (mem_awready),
        .mem_wdata_o   (mem_wdata),
        .mem_wstrb_o   (mem_wstrb),
        .mem_wtag_o    (mem_wtag),
        .mem_wvalid_o  (mem_wvalid),
        .mem_wready_i  (mem_wready),
        .mem_bresp_i   (mem_bresp),
        .mem_bvalid_i  (mem_bvalid),
        .mem_bready_o  (mem_bready),
        .mem_araddr_o  (mem_araddr),
        .mem_arvalid_o (mem_arvalid),
        .mem_arready_i (mem_arready),
        .mem_rdata_i   (mem_rdata),
        .mem_rtag_i    (mem_rtag),
        .mem_rresp_i   (mem_rresp),
        .mem_rvalid_i  (mem_rvalid),
        .mem_rready_o  (mem_rready),
        .cfg_awaddr_o  (cfg_awaddr),
        .cfg_awvalid_o (cfg_awvalid),
        .cfg_awready_i (cfg_awready),
        .cfg_wdata_o   (cfg_wdata),
        .cfg_wstrb_o   (cfg_wstrb),
        .cfg_wvalid_o  (cfg_wvalid),
        .cfg_wready_i  (cfg_wready),
        .cfg_bresp_i   (cfg_bresp),
        .cfg_bvalid_i  (cfg_bvalid),
        .cfg_bready_o  (cfg_bready),
        .cfg_araddr_o  (cfg_araddr),
        .cfg_arvalid_o (cfg_arvalid),
        .cfg_arready_i (cfg_arready),
        .cfg_rdata_i   (cfg_rdata),
        .cfg_rresp_i   (cfg_rresp),
        .cfg_rvalid_i  (cfg_rvalid),
        .cfg_rready_o  (cfg_rready)
    );

    adam_axil_to_mem i_axil_to_mem (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .awaddr_i    (mem_awaddr),
        .awvalid_i   (mem_awvalid),
        .awready_o   (mem_awready),
        .wdata_i     (mem_wdata),
        .wstrb_i     (mem_wstrb),
        .wtag_i      (mem_wtag),
        .wvalid_i    (mem_wvalid),
        .wready_o    (mem_wready),
        .bresp_o     (mem_bresp),
        .bvalid_o    (mem_bvalid),
        .bready_i    (mem_bready),
        .araddr_i    (mem_araddr),
        .arvalid_i   (mem_arvalid),
        .arready_o   (mem_arready),
        .rdata_o     (mem_rdata),
        .rtag_o      (mem_rtag),
        .rresp_o     (mem_rresp),
        .rvalid_o    (mem_rvalid),
        .rready_i    (mem_rready),
        .pause_req_i (mem_pause_req),
        .pause_ack_o (mem_pause_ack),
        .ram_req_o   (ram_req),
        .ram_we_o    (ram_we),
        .ram_index_o (ram_index),
        .ram_be_o    (ram_be),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .tag_wdata_o (tag_wdata),
        .tag_rdata_i (tag_rdata)
    );

    adam_syscfg i_syscfg (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .awaddr_i        (cfg_awaddr),
        .awvalid_i       (cfg_awvalid),
        .awready_o       (cfg_awready),
        .wdata_i         (cfg_wdata),
        .wstrb_i         (cfg_wstrb),
        .wvalid_i        (cfg_wvalid),
        .wready_o        (cfg_wready),
        .bresp_o         (cfg_bresp),
        .bvalid_o        (cfg_bvalid),
        .bready_i        (cfg_bready),
        .araddr_i        (cfg_araddr),
        .arvalid_i       (cfg_arvalid),
        .arready_o       (cfg_arready),
        .rdata_o         (cfg_rdata),
        .rresp_o         (cfg_rresp),
        .rvalid_o        (cfg_rvalid),
        .rready_i        (cfg_rready),
        .mem_pause_req_o (mem_pause_req),
        .mem_pause_ack_i (mem_pause_ack)
    );

    adam_mem #(
        .SIZE   (MEM_WORDS),
        .word_t (data_t)
    ) i_data_mem (
        .clk_i   (clk_i),
        .req_i   (ram_req),
        .we_i    (ram_we),
        .index_i (ram_index),
        .be_i    (ram_be),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    // Tag RAM follows the data RAM access
    adam_mem #(
        .SIZE   (MEM_WORDS),
        .word_t (tag_t)
    ) i_tag_mem (
        .clk_i   (clk_i),
        .req_i   (ram_req),
        .we_i    (ram_we),
        .index_i (ram_index),
        .be_i    (ram_be),
        .wdata_i (tag_wdata),
        .rdata_o (tag_rdata)
    );

endmodule

// ==== hw/adam_axil_to_mem.sv ====
`timescale 1ns/10ps

module adam_axil_to_mem (
    input  logic                                  clk_i,
    input  logic                                  reset_i,

    input  adam_pkg::addr_t                       awaddr_i,
    input  logic                                  awvalid_i,
    output logic                                  awready_o,

    input  adam_pkg::data_t                       wdata_i,
    input  adam_pkg::strb_t                       wstrb_i,
    input  logic                                  wtag_i,
    input  logic                                  wvalid_i,
    output logic                                  wready_o,

    output adam_pkg::resp_t                       bresp_o,
    output logic                                  bvalid_o,
    input  logic                                  bready_i,

    input  adam_pkg::addr_t                       araddr_i,
    input  logic                                  arvalid_i,
    output logic                                  arready_o,

    output adam_pkg::data_t                       rdata_o,
    output adam_pkg::tag_t                        rtag_o,
    output adam_pkg::resp_t                       rresp_o,
    output logic                                  rvalid_o,
    input  logic                                  rready_i,

    input  logic                                  pause_req_i,
    output logic                                  pause_ack_o,

    output logic                                  ram_req_o,
    output logic                                  ram_we_o,
    output logic [$clog2(adam_pkg::MEM_WORDS)-1:0] ram_index_o,
    output adam_pkg::strb_t                       ram_be_o,
    output adam_pkg::data_t                       ram_wdata_o,
    input  adam_pkg::data_t                       ram_rdata_i,
    output adam_pkg::tag_t                        tag_wdata_o,
    input  adam_pkg::tag_t                        tag_rdata_i
);

    import adam_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic  pending_q;
    logic  pend_wr_q;
    logic  rd_first_q;
    data_t rdata_q;
    tag_t  rtag_q;
    logic  wr_go;
    logic  rd_go;

    // Writes win over reads, nothing new while paused or busy
    assign wr_go = awvalid_i && wvalid_i && !pending_q && !pause_req_i;
    assign rd_go = arvalid_i && !(awvalid_i && wvalid_i) && !pending_q && !pause_req_i;

    assign awready_o = wr_go;
    assign wready_o  = wr_go;
    assign arready_o = rd_go;

    // RAM and tag RAM are accessed on the accepting edge
    assign ram_req_o   = wr_go || rd_go;
    assign ram_we_o    = wr_go;
    assign ram_index_o = wr_go ? awaddr_i[IDX_W+1:2] : araddr_i[IDX_W+1:2];
    assign ram_be_o    = wstrb_i;
    assign ram_wdata_o = wdata_i;
    assign tag_wdata_o = {STRB_WIDTH{wtag_i}};

    assign bvalid_o = pending_q && pend_wr_q;
    assign rvalid_o = pending_q && !pend_wr_q;
    assign bresp_o  = RESP_OKAY;
    assign rresp_o  = RESP_OKAY;

    // Fresh RAM output in the first cycle, the captured copy afterwards
    assign rdata_o = rd_first_q ? ram_rdata_i : rdata_q;
    assign rtag_o  = rd_first_q ? tag_rdata_i : rtag_q;

    assign pause_ack_o = pause_req_i && !pending_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
            pend_wr_q <= 1'b0;
        end else if (wr_go || rd_go) begin
            pending_q <= 1'b1;
            pend_wr_q <= wr_go;
        end else if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_first_q <= 1'b0;
        end else begin
            rd_first_q <= rd_go;
        end
    end

    // Hold read payload under back-pressure
    always_ff @(posedge clk_i) begin
        if (rd_first_q) begin
            rdata_q <= ram_rdata_i;
            rtag_q  <= tag_rdata_i;
        end
    end

endmodule

// ==== hw/adam_fabric.sv ====
`timescale 1ns/10ps

module adam_fabric (
    input  logic            clk_i,
    input  logic            reset_i,

    // Manager port
    input  adam_pkg::addr_t s_awaddr_i,
    input  logic            s_awvalid_i,
    output logic            s_awready_o,
    input  adam_pkg::data_t s_wdata_i,
    input  adam_pkg::strb_t s_wstrb_i,
    input  logic            s_wtag_i,
    input  logic            s_wvalid_i,
    output logic            s_wready_o,
    output adam_pkg::resp_t s_bresp_o,
    output logic            s_bvalid_o,
    input  logic            s_bready_i,
    input  adam_pkg::addr_t s_araddr_i,
    input  logic            s_arvalid_i,
    output logic            s_arready_o,
    output adam_pkg::data_t s_rdata_o,
    output adam_pkg::tag_t  s_rtag_o,
    output adam_pkg::resp_t s_rresp_o,
    output logic            s_rvalid_o,
    input  logic            s_rready_i,

    // Memory bridge
    output adam_pkg::addr_t mem_awaddr_o,
    output logic            mem_awvalid_o,
    input  logic            mem_awready_i,
    output adam_pkg::data_t mem_wdata_o,
    output adam_pkg::strb_t mem_wstrb_o,
    output logic            mem_wtag_o,
    output logic            mem_wvalid_o,
    input  logic            mem_wready_i,
    input  adam_pkg::resp_t mem_bresp_i,
    input  logic            mem_bvalid_i,
    output logic            mem_bready_o,
    output adam_pkg::addr_t mem_araddr_o,
    output logic            mem_arvalid_o,
    input  logic            mem_arready_i,
    input  adam_pkg::data_t mem_rdata_i,
    input  adam_pkg::tag_t  mem_rtag_i,
    input  adam_pkg::resp_t mem_rresp_i,
    input  logic            mem_rvalid_i,
    output logic            mem_rready_o,

    // Syscfg block
    output adam_pkg::addr_t cfg_awaddr_o,
    output logic            cfg_awvalid_o,
    input  logic            cfg_awready_i,
    output adam_pkg::data_t cfg_wdata_o,
    output adam_pkg::strb_t cfg_wstrb_o,
    output logic            cfg_wvalid_o,
    input  logic            cfg_wready_i,
    input  adam_pkg::resp_t cfg_bresp_i,
    input  logic            cfg_bvalid_i,
    output logic            cfg_bready_o,
    output adam_pkg::addr_t cfg_araddr_o,
    output logic            cfg_arvalid_o,
    input  logic            cfg_arready_i,
    input  adam_pkg::data_t cfg_rdata_i,
    input  adam_pkg::resp_t cfg_rresp_i,
    input  logic            cfg_rvalid_i,
    output logic            cfg_rready_o
);

    import adam_pkg::*;

    logic wr_busy_q;
    logic wr_cfg_q;
    logic rd_busy_q;
    logic rd_cfg_q;
    logic aw_cfg;
    logic ar_cfg;

    // Target decode, high means syscfg
    assign aw_cfg = |(s_awaddr_i & SYSCFG_BASE);
    assign ar_cfg = |(s_araddr_i & SYSCFG_BASE);

    assign mem_awaddr_o = s_awaddr_i;
    assign cfg_awaddr_o = s_awaddr_i;
    assign mem_wdata_o  = s_wdata_i;
    assign cfg_wdata_o  = s_wdata_i;
    assign mem_wstrb_o  = s_wstrb_i;
    assign cfg_wstrb_o  = s_wstrb_i;
    assign mem_wtag_o   = s_wtag_i;
    assign mem_araddr_o = s_araddr_i;
    assign cfg_araddr_o = s_araddr_i;

    // Write request steering, held off while a B is outstanding
    assign mem_awvalid_o = s_awvalid_i && !wr_busy_q && !aw_cfg;
    assign cfg_awvalid_o = s_awvalid_i && !wr_busy_q && aw_cfg;
    assign mem_wvalid_o  = s_wvalid_i && !wr_busy_q && !aw_cfg;
    assign cfg_wvalid_o  = s_wvalid_i && !wr_busy_q && aw_cfg;
    assign s_awready_o   = !wr_busy_q && (aw_cfg ? cfg_awready_i : mem_awready_i);
    assign s_wready_o    = !wr_busy_q && (aw_cfg ? cfg_wready_i : mem_wready_i);

    assign s_bvalid_o   = wr_busy_q && (wr_cfg_q ? cfg_bvalid_i : mem_bvalid_i);
    assign s_bresp_o    = wr_cfg_q ? cfg_bresp_i : mem_bresp_i;
    assign mem_bready_o = s_bready_i && wr_busy_q && !wr_cfg_q;
    assign cfg_bready_o = s_bready_i && wr_busy_q && wr_cfg_q;

    // Read request steering
    assign mem_arvalid_o = s_arvalid_i && !rd_busy_q && !ar_cfg;
    assign cfg_arvalid_o = s_arvalid_i && !rd_busy_q && ar_cfg;
    assign s_arready_o   = !rd_busy_q && (ar_cfg ? cfg_arready_i : mem_arready_i);

    assign s_rvalid_o   = rd_busy_q && (rd_cfg_q ? cfg_rvalid_i : mem_rvalid_i);
    assign s_rdata_o    = rd_cfg_q ? cfg_rdata_i : mem_rdata_i;
    assign s_rresp_o    = rd_cfg_q ? cfg_rresp_i : mem_rresp_i;
    // Syscfg carries no tags
    assign s_rtag_o     = rd_cfg_q ? '0 : mem_rtag_i;
    assign mem_rready_o = s_rready_i && rd_busy_q && !rd_cfg_q;
    assign cfg_rready_o = s_rready_i && rd_busy_q && rd_cfg_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_busy_q <= 1'b0;
            wr_cfg_q  <= 1'b0;
        end else if (s_awvalid_i && s_awready_o) begin
            wr_busy_q <= 1'b1;
            wr_cfg_q  <= aw_cfg;
        end else if (s_bvalid_o && s_bready_i) begin
            wr_busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_busy_q <= 1'b0;
            rd_cfg_q  <= 1'b0;
        end else if (s_arvalid_i && s_arready_o) begin
            rd_busy_q <= 1'b1;
            rd_cfg_q  <= ar_cfg;
        end else if (s_rvalid_o && s_rready_i) begin
            rd_busy_q <= 1'b0;
        end
    end

endmodule

// ==== hw/adam_mem.sv ====
`timescale 1ns/10ps

module adam_mem #(
    parameter int  SIZE   = adam_pkg::MEM_WORDS,
    parameter type word_t = adam_pkg::data_t
) (
    input  logic                    clk_i,

    input  logic                    req_i,
    input  logic                    we_i,
    input  logic [$clog2(SIZE)-1:0] index_i,
    input  adam_pkg::strb_t         be_i,
    input  word_t                   wdata_i,
    output word_t                   rdata_o
);

    import adam_pkg::*;

    // One lane per byte strobe
    localparam int LANE_W = $bits(word_t) / STRB_WIDTH;

    word_t mem_q [SIZE];

    // Byte-laned write
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (be_i[i]) begin
                    mem_q[index_i][i*LANE_W +: LANE_W] <= wdata_i[i*LANE_W +: LANE_W];
                end
            end
        end
    end

    // Read-first, so a write in the same cycle is not seen
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= mem_q[index_i];
        end
    end

endmodule

// ==== hw/adam_pkg.sv ====
package adam_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // DIFT tags, bit n tags byte n of the word
    typedef logic [STRB_WIDTH-1:0] tag_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // RAM depth in words
    localparam int MEM_WORDS = 256;

    // Syscfg window is selected by address bit 16
    localparam addr_t SYSCFG_BASE = 32'h0001_0000;

    // Syscfg register offsets
    localparam addr_t SYSCFG_CTRL_OFS   = 32'h0000_0000;
    localparam addr_t SYSCFG_STATUS_OFS = 32'h0000_0004;

endpackage

// ==== hw/adam_syscfg.sv ====
`timescale 1ns/10ps

module adam_syscfg (
    input  logic            clk_i,
    input  logic            reset_i,

    input  adam_pkg::addr_t awaddr_i,
    input  logic            awvalid_i,
    output logic            awready_o,

    input  adam_pkg::data_t wdata_i,
    input  adam_pkg::strb_t wstrb_i,
    input  logic            wvalid_i,
    output logic            wready_o,

    output adam_pkg::resp_t bresp_o,
    output logic            bvalid_o,
    input  logic            bready_i,

    input  adam_pkg::addr_t araddr_i,
    input  logic            arvalid_i,
    output logic            arready_o,

    output adam_pkg::data_t rdata_o,
    output adam_pkg::resp_t rresp_o,
    output logic            rvalid_o,
    input  logic            rready_i,

    output logic            mem_pause_req_o,
    input  logic            mem_pause_ack_i
);

    import adam_pkg::*;

    // Offset bits lie below the window select bit
    localparam int OFS_W = $clog2(SYSCFG_BASE);

    logic  pending_q;
    logic  pend_wr_q;
    logic  ctrl_pause_q;
    data_t rdata_q;
    logic  wr_go;
    logic  rd_go;

    assign wr_go = awvalid_i && wvalid_i && !pending_q;
    assign rd_go = arvalid_i && !(awvalid_i && wvalid_i) && !pending_q;

    assign awready_o = wr_go;
    assign wready_o  = wr_go;
    assign arready_o = rd_go;

    assign bvalid_o = pending_q && pend_wr_q;
    assign rvalid_o = pending_q && !pend_wr_q;
    assign bresp_o  = RESP_OKAY;
    assign rresp_o  = RESP_OKAY;
    assign rdata_o  = rdata_q;

    assign mem_pause_req_o = ctrl_pause_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
            pend_wr_q <= 1'b0;
        end else if (wr_go || rd_go) begin
            pending_q <= 1'b1;
            pend_wr_q <= wr_go;
        end else if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
            pending_q <= 1'b0;
        end
    end

    // Only the pause bit of CTRL is writable
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_pause_q <= 1'b0;
        end else if (wr_go && wstrb_i[0] &&
                     awaddr_i[OFS_W-1:0] == SYSCFG_CTRL_OFS[OFS_W-1:0]) begin
            ctrl_pause_q <= wdata_i[0];
        end
    end

    // Unmapped offsets read as zero
    always_ff @(posedge clk_i) begin
        if (rd_go) begin
            rdata_q <= '0;
            if (araddr_i[OFS_W-1:0] == SYSCFG_CTRL_OFS[OFS_W-1:0]) begin
                rdata_q[0] <= ctrl_pause_q;
            end else if (araddr_i[OFS_W-1:0] == SYSCFG_STATUS_OFS[OFS_W-1:0]) begin
                rdata_q[0] <= mem_pause_ack_i;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module adam_tb -Mdir obj_dir -o adam_sim -f files.f > sim.log 2>&1 \
    && ./obj_dir/adam_sim >> sim.log 2>&1 \
    || echo "Build or simulation stopped with an error" >> sim.log

grep -qx "=== PASS ===" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb/adam_tb.sv ====
`timescale 1ns/10ps

module adam_tb;

    import adam_pkg::*;

    localparam int    CLK_PERIOD    = 10;
    localparam int    RESET_CYCLES  = 16;
    localparam int    N_RAND_WR     = 200;
    localparam int    N_MISC        = 24;
    localparam int    N_TX          = 2 * MEM_WORDS + N_RAND_WR + N_MISC;
    // Memory window only, word aligned
    localparam addr_t MEM_ADDR_MASK = 32'hFFFE_FFFC;

    logic  clk;
    logic  reset;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    strb_t wstrb;
    logic  wtag;
    logic  wvalid;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  bready;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    tag_t  rtag;
    resp_t rresp;
    logic  rvalid;
    logic  rready;

    // Reference model
    data_t mem_model [MEM_WORDS];
    tag_t  tag_model [MEM_WORDS];
    logic  ctrl_model;

    int          check_cnt;
    int          mismatch_cnt;
    int          error_cnt;
    addr_t       addr;
    logic [31:0] rnd;

    adam dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .s_awaddr_i  (awaddr),
        .s_awvalid_i (awvalid),
        .s_awready_o (awready),
        .s_wdata_i   (wdata),
        .s_wstrb_i   (wstrb),
        .wtag_i      (wtag),
        .s_wvalid_i  (wvalid),
        .s_wready_o  (wready),
        .s_bresp_o   (bresp),
        .s_bvalid_o  (bvalid),
        .s_bready_i  (bready),
        .s_araddr_i  (araddr),
        .s_arvalid_i (arvalid),
        .s_arready_o (arready),
        .s_rdata_o   (rdata),
        .rtag_o      (rtag),
        .s_rresp_o   (rresp),
        .s_rvalid_o  (rvalid),
        .s_rready_i  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        mismatch_cnt++;
        $display("MISMATCH %s expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
    endtask

    task automatic report_error(input string msg);
        error_cnt++;
        $display("ERROR %s at %0t", msg, $time);
    endtask

    task automatic print_counts();
        $display("Checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, error_cnt);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_cnt++;
        assert (act == exp) else report_mismatch(name, exp, act);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic advance_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] rand_word();
        return $urandom();
    endfunction

    // STATUS follows CTRL while no memory access is pending
    function automatic data_t cfg_expect(input addr_t ofs);
        if (ofs[15:0] == SYSCFG_CTRL_OFS[15:0] || ofs[15:0] == SYSCFG_STATUS_OFS[15:0]) begin
            return {31'd0, ctrl_model};
        end
        return '0;
    endfunction

    task automatic do_write(input addr_t a, input data_t data, input strb_t strb,
                            input logic tag);
        int unsigned stall;
        stall   = $urandom_range(3, 0);
        awaddr  = a;
        wdata   = data;
        wstrb   = strb;
        wtag    = tag;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (stall == 0);
        @(negedge clk);
        while (!(awready && wready)) begin
            if (awready != wready) begin
                report_error("write address and write data were not accepted together");
            end
            @(negedge clk);
        end
        check_value("s_bvalid_o", 32'd0, 32'(bvalid));
        advance_cycle();
        // The request is offered again while the response is held back
        awvalid = (stall != 0);
        wvalid  = (stall != 0);
        repeat (stall) begin
            @(negedge clk);
            check_value("s_bvalid_o", 32'd1, 32'(bvalid));
            check_value("s_awready_o", 32'd0, 32'(awready));
            advance_cycle();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge clk);
        check_value("s_bvalid_o", 32'd1, 32'(bvalid));
        check_value("s_bresp_o", 32'(RESP_OKAY), 32'(bresp));
        advance_cycle();
        bready = 1'b0;
    endtask

    task automatic check_read_beat(input data_t exp_data, input tag_t exp_tag,
                                   input bit cfg_target);
        check_value("s_rvalid_o", 32'd1, 32'(rvalid));
        check_value("s_rresp_o", 32'(RESP_OKAY), 32'(rresp));
        check_value("s_rdata_o", exp_data, rdata);
        if (!cfg_target) begin
            check_value("rtag_o", 32'(exp_tag), 32'(rtag));
        end
    endtask

    task automatic do_read(input addr_t a, input data_t exp_data, input tag_t exp_tag,
                           input bit cfg_target);
        int unsigned stall;
        stall   = $urandom_range(3, 0);
        araddr  = a;
        arvalid = 1'b1;
        rready  = (stall == 0);
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        check_value("s_rvalid_o", 32'd0, 32'(rvalid));
        advance_cycle();
        // The request is offered again while the response is held back
        arvalid = (stall != 0);
        repeat (stall) begin
            @(negedge clk);
            check_read_beat(exp_data, exp_tag, cfg_target);
            check_value("s_arready_o", 32'd0, 32'(arready));
            advance_cycle();
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        check_read_beat(exp_data, exp_tag, cfg_target);
        advance_cycle();
        rready = 1'b0;
    endtask

    // Only strobed bytes and their tag bits change
    task automatic write_mem(input addr_t a, input data_t data, input strb_t strb,
                             input logic tag);
        logic [7:0] idx;
        idx = a[9:2];
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) begin
                mem_model[idx][8*b +: 8] = data[8*b +: 8];
                tag_model[idx][b]        = tag;
            end
        end
        do_write(a, data, strb, tag);
    endtask

    task automatic read_mem(input addr_t a);
        logic [7:0] idx;
        idx = a[9:2];
        do_read(a, mem_model[idx], tag_model[idx], 1'b0);
    endtask

    task automatic write_cfg(input addr_t ofs, input data_t data);
        if (ofs[15:0] == SYSCFG_CTRL_OFS[15:0]) begin
            ctrl_model = data[0];
        end
        do_write(SYSCFG_BASE | ofs, data, 4'hF, 1'b0);
    endtask

    task automatic read_cfg(input addr_t ofs);
        do_read(SYSCFG_BASE | ofs, cfg_expect(ofs), '0, 1'b1);
    endtask

    initial begin
        #((N_TX * 40 + RESET_CYCLES) * CLK_PERIOD);
        report_error("watchdog expired, the DUT stopped responding");
        print_counts();
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(55));
        check_cnt    = 0;
        mismatch_cnt = 0;
        error_cnt    = 0;
        ctrl_model   = 1'b0;
        reset        = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wtag         = 1'b0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Quiet bus after reset
        repeat (4) begin
            @(negedge clk);
            check_value("s_bvalid_o", 32'd0, 32'(bvalid));
            check_value("s_rvalid_o", 32'd0, 32'(rvalid));
        end
        advance_cycle();
        read_cfg(SYSCFG_CTRL_OFS);
        read_cfg(SYSCFG_STATUS_OFS);

        // Fill every word so the model is fully known
        for (int i = 0; i < MEM_WORDS; i++) begin
            rnd = rand_word();
            write_mem(i * 4, rand_word(), 4'hF, rnd[0]);
        end

        for (int i = 0; i < N_RAND_WR; i++) begin
            addr = rand_word() & MEM_ADDR_MASK;
            rnd  = rand_word();
            write_mem(addr, rand_word(), rnd[3:0], rnd[4]);
        end

        // Above 1 KiB the index wraps
        write_mem(32'h0000_07F0, rand_word(), 4'hF, 1'b1);
        read_mem(32'h0000_03F0);

        for (int i = 0; i < MEM_WORDS; i++) begin
            rnd = rand_word() & MEM_ADDR_MASK;
            read_mem({rnd[31:10], i[7:0], 2'b00});
        end

        // Pause holds off a memory read until CTRL is cleared
        write_cfg(SYSCFG_CTRL_OFS, 32'h1);
        read_cfg(SYSCFG_STATUS_OFS);
        addr    = rand_word() & MEM_ADDR_MASK;
        araddr  = addr;
        arvalid = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_value("s_arready_o", 32'd0, 32'(arready));
        end
        advance_cycle();
        fork
            write_cfg(SYSCFG_CTRL_OFS, 32'h0);
            read_mem(addr);
        join
        read_cfg(SYSCFG_STATUS_OFS);

        // Unmapped offsets and the read-only STATUS
        read_cfg(32'h0000_0008);
        read_cfg(32'h0000_000C);
        read_cfg(32'h0000_0100);
        write_cfg(32'h0000_0008, 32'h1);
        read_cfg(SYSCFG_CTRL_OFS);
        write_cfg(SYSCFG_CTRL_OFS, 32'h1);
        write_cfg(32'h0000_000C, 32'h0);
        write_cfg(SYSCFG_STATUS_OFS, 32'h0);
        read_cfg(SYSCFG_CTRL_OFS);
        write_cfg(SYSCFG_CTRL_OFS, 32'h0);
        read_cfg(SYSCFG_CTRL_OFS);

        repeat (2) advance_cycle();
        print_counts();
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
